/* hw/cpu_pkg.sv */
`default_nettype none
// ISA definitions shared by the pipeline stages
// Codes missing from opcode_e are illegal and run as NOP after raising err

package cpu_pkg;

   localparam int DATA_W = 16;  // Data and instruction width
   localparam int REG_AW = 3;   // Eight registers
   localparam int OPC_W  = 5;   // Opcode field, instr[15:11]

   // Instruction formats
   //   ALU_R           opc | rs[10:8] | rt[7:5] | rd[4:2] | func[1:0]
   //   ADDI, LD, ST    opc | rs[10:8] | rd[7:5] | imm5[4:0]
   //   LBI, BEQZ/BNEZ  opc | rs[10:8] | imm8[7:0]
   //   J               opc | imm11[10:0]
   typedef enum logic [OPC_W-1:0] {
      HALT  = 5'b00000,
      NOP   = 5'b00001,
      J     = 5'b00100,  // PC + 2 + imm11
      ADDI  = 5'b01000,
      BEQZ  = 5'b01100,
      BNEZ  = 5'b01101,
      ST    = 5'b10000,  // mem[rs + imm5] = rd field register
      LD    = 5'b10001,
      LBI   = 5'b11000,  // rs field is the destination
      ALU_R = 5'b11011   // Function in instr[1:0]
   } opcode_e;

   // ALU_R function codes in instr[1:0]
   localparam logic [1:0] FUNC_ADD = 2'b00;
   localparam logic [1:0] FUNC_SUB = 2'b01;  // rs - rt
   localparam logic [1:0] FUNC_XOR = 2'b10;
   localparam logic [1:0] FUNC_AND = 2'b11;

   typedef enum logic [2:0] {
      ADD,
      SUB,
      AND,
      XOR,
      PASS_B  // Second operand straight through, used by LBI
   } alu_op_e;

endpackage

`default_nettype wire

/* hw/fetch_stage.sv */
`default_nettype none
// PC is a byte address that steps by 2. Instruction memory uses pc[MEM_AW:1]
// Host writes to instruction memory take effect only while run is low
// Fetch stops after a HALT and restarts only through reset or a redirect

module fetch_stage
   import cpu_pkg::*;
#(
   parameter int MEM_AW = 8
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              run,
   input  logic              stall,
   input  logic              redirect,
   input  logic [DATA_W-1:0] redirect_pc,
   input  logic              host_we_imem,
   input  logic [MEM_AW-1:0] host_addr,
   input  logic [DATA_W-1:0] host_wdata,
   input  logic              halt_seen,
   output logic [DATA_W-1:0] instr_d,
   output logic [DATA_W-1:0] pc_d,
   output logic              valid_d
);

   logic [DATA_W-1:0] imem [2**MEM_AW];
   logic [DATA_W-1:0] pc;
   logic [DATA_W-1:0] instr_f;
   logic [DATA_W-1:0] pc_next;
   logic              stop;      // HALT fetched
   logic              fetch_en;
   logic              is_halt;

   assign instr_f  = imem[pc[MEM_AW:1]];
   assign pc_next  = pc + DATA_W'(2);
   assign fetch_en = run && !stop && !halt_seen;
   assign is_halt  = opcode_e'(instr_f[DATA_W-1 -: OPC_W]) == HALT;

   always_ff @(posedge clk) begin
      if (!run && host_we_imem) begin
         imem[host_addr] <= host_wdata;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc      <= '0;
         valid_d <= 1'b0;
         stop    <= 1'b0;
      end else if (redirect) begin
         pc      <= redirect_pc;
         valid_d <= 1'b0;
         stop    <= 1'b0;   // Any fetched HALT was on the wrong path
      end else if (!stall) begin
         valid_d <= fetch_en;
         if (fetch_en) begin
            pc <= pc_next;
            if (is_halt) stop <= 1'b1;
         end
      end
   end

   // Fetch/decode payload
   always_ff @(posedge clk) begin
      if (!stall && fetch_en) begin
         instr_d <= instr_f;
         pc_d    <= pc_next;
      end
   end

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
`default_nettype none
// Register file has no reset, so programs must load a register before using it
// A write from writeback is bypassed to a read of the same register
// err is sticky until reset. A flushed illegal opcode does not set it

module decode_stage
   import cpu_pkg::*;
(
   input  logic               clk,
   input  logic               arst_n,
   input  logic [DATA_W-1:0]  instr_d,
   input  logic [DATA_W-1:0]  pc_d,
   input  logic               valid_d,
   input  logic               bubble,
   input  logic               flush,
   input  logic               wb_we,
   input  logic [REG_AW-1:0]  wb_rd,
   input  logic [DATA_W-1:0]  wb_data,
   output logic [REG_AW-1:0]  rs_d,
   output logic [REG_AW-1:0]  rt_d,
   output logic               uses_rs_d,
   output logic               uses_rt_d,
   output opcode_e            opc_e,
   output cpu_pkg::alu_op_e   alu_op_e,
   output logic [DATA_W-1:0]  a_e,
   output logic [DATA_W-1:0]  b_e,
   output logic [DATA_W-1:0]  imm_e,
   output logic [DATA_W-1:0]  pc_e,
   output logic [REG_AW-1:0]  rd_e,
   output logic               we_e,
   output logic               valid_e,
   output logic               err
);

   logic [DATA_W-1:0] rf [2**REG_AW];
   opcode_e           opc;
   cpu_pkg::alu_op_e  alu_op;
   logic [REG_AW-1:0] rd;
   logic              we;
   logic              illegal;
   logic [DATA_W-1:0] imm;
   logic [DATA_W-1:0] rs_val;
   logic [DATA_W-1:0] rt_val;
   logic              load_e;   // Real instruction enters execute

   assign opc  = opcode_e'(instr_d[DATA_W-1 -: OPC_W]);
   assign rs_d = instr_d[10:8];
   assign rt_d = instr_d[7:5];

   always_comb begin
      alu_op    = ADD;
      uses_rs_d = 1'b0;
      uses_rt_d = 1'b0;
      rd        = instr_d[7:5];
      we        = 1'b0;
      illegal   = 1'b0;
      imm       = {{(DATA_W-5){instr_d[4]}}, instr_d[4:0]};  // imm5
      case (opc)
         NOP, HALT: ;
         ALU_R: begin
            uses_rs_d = 1'b1;
            uses_rt_d = 1'b1;
            rd        = instr_d[4:2];
            we        = 1'b1;
            case (instr_d[1:0])
               FUNC_ADD: alu_op = ADD;
               FUNC_SUB: alu_op = SUB;
               FUNC_XOR: alu_op = XOR;
               default:  alu_op = AND;
            endcase
         end
         ADDI, LD: begin
            uses_rs_d = 1'b1;
            we        = 1'b1;
         end
         ST: begin
            uses_rs_d = 1'b1;
            uses_rt_d = 1'b1;   // Store data from the rd field
         end
         LBI: begin
            rd     = instr_d[10:8];
            we     = 1'b1;
            alu_op = PASS_B;
            imm    = {{(DATA_W-8){instr_d[7]}}, instr_d[7:0]};
         end
         BEQZ, BNEZ: begin
            uses_rs_d = 1'b1;
            imm       = {{(DATA_W-8){instr_d[7]}}, instr_d[7:0]};
         end
         J: imm = {{(DATA_W-11){instr_d[10]}}, instr_d[10:0]};
         default: illegal = 1'b1;
      endcase
   end

   // Register file with writeback bypass
   always_ff @(posedge clk) begin
      if (wb_we) rf[wb_rd] <= wb_data;
   end

   assign rs_val = (wb_we && wb_rd == rs_d) ? wb_data : rf[rs_d];
   assign rt_val = (wb_we && wb_rd == rt_d) ? wb_data : rf[rt_d];

   assign load_e = valid_d && !bubble && !flush;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_e <= 1'b0;
         we_e    <= 1'b0;
         err     <= 1'b0;
      end else begin
         valid_e <= load_e;
         we_e    <= load_e && we;
         if (valid_d && !flush && illegal) err <= 1'b1;
      end
   end

   // Decode/execute payload
   always_ff @(posedge clk) begin
      opc_e    <= illegal ? NOP : opc;
      alu_op_e <= alu_op;
      a_e      <= rs_val;
      b_e      <= rt_val;
      imm_e    <= imm;
      pc_e     <= pc_d;
      rd_e     <= rd;
   end

endmodule

`default_nettype wire

/* hw/hazard_unit.sv */
`default_nettype none
// Stall only, no forwarding. Writeback is covered by the register file bypass
// we_e and we_m must already be qualified by their stage valid bits

module hazard_unit
   import cpu_pkg::*;
(
   input  logic [REG_AW-1:0] rs_d,
   input  logic [REG_AW-1:0] rt_d,
   input  logic              uses_rs_d,
   input  logic              uses_rt_d,
   input  logic              valid_d,
   input  logic [REG_AW-1:0] rd_e,
   input  logic              we_e,
   input  logic [REG_AW-1:0] rd_m,
   input  logic              we_m,
   output logic              stall,
   output logic              bubble
);

   logic rs_hit_e;
   logic rs_hit_m;
   logic rt_hit_e;
   logic rt_hit_m;

   // Sources against writers still in flight
   assign rs_hit_e = uses_rs_d && we_e && (rs_d == rd_e);
   assign rs_hit_m = uses_rs_d && we_m && (rs_d == rd_m);
   assign rt_hit_e = uses_rt_d && we_e && (rt_d == rd_e);
   assign rt_hit_m = uses_rt_d && we_m && (rt_d == rd_m);

   assign stall  = valid_d && (rs_hit_e || rs_hit_m || rt_hit_e || rt_hit_m);
   assign bubble = stall;   // Hold decode, send an empty slot to execute

endmodule

`default_nettype wire

/* hw/execute_stage.sv */
`default_nettype none
// Branches and J resolve here. Target is pc_e (already PC + 2) plus imm
// A taken redirect flushes the two younger slots in fetch and decode

module execute_stage
   import cpu_pkg::*;
(
   input  logic               clk,
   input  logic               arst_n,
   input  opcode_e            opc_e,
   input  cpu_pkg::alu_op_e   alu_op_e,
   input  logic [DATA_W-1:0]  a_e,
   input  logic [DATA_W-1:0]  b_e,
   input  logic [DATA_W-1:0]  imm_e,
   input  logic [DATA_W-1:0]  pc_e,
   input  logic [REG_AW-1:0]  rd_e,
   input  logic               we_e,
   input  logic               valid_e,
   output logic               redirect,
   output logic [DATA_W-1:0]  redirect_pc,
   output logic [DATA_W-1:0]  alu_m,
   output logic [DATA_W-1:0]  st_data_m,
   output opcode_e            opc_m,
   output logic [REG_AW-1:0]  rd_m,
   output logic               we_m,
   output logic               valid_m
);

   logic [DATA_W-1:0] op_b;
   logic [DATA_W-1:0] alu;
   logic              use_imm;
   logic              taken;

   assign use_imm = opc_e inside {ADDI, LBI, LD, ST};
   assign op_b    = use_imm ? imm_e : b_e;

   always_comb begin
      case (alu_op_e)
         ADD:     alu = a_e + op_b;
         SUB:     alu = a_e - op_b;
         AND:     alu = a_e & op_b;
         XOR:     alu = a_e ^ op_b;
         PASS_B:  alu = op_b;
         default: alu = op_b;
      endcase
   end

   always_comb begin
      case (opc_e)
         BEQZ:    taken = (a_e == '0);
         BNEZ:    taken = (a_e != '0);
         J:       taken = 1'b1;
         default: taken = 1'b0;
      endcase
   end

   assign redirect    = valid_e && taken;
   assign redirect_pc = pc_e + imm_e;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_m <= 1'b0;
         we_m    <= 1'b0;
      end else begin
         valid_m <= valid_e;
         we_m    <= we_e;    // Already gated by valid in decode
      end
   end

   // Execute/memory payload
   always_ff @(posedge clk) begin
      alu_m     <= alu;
      st_data_m <= b_e;
      opc_m     <= opc_e;
      rd_m      <= rd_e;
   end

endmodule

`default_nettype wire

/* hw/memory_stage.sv */
`default_nettype none
// Data memory is word addressed by the low MEM_AW bits of the ALU result
// host_rdata follows host_addr one cycle later. Host writes need run low
// halted is sticky until reset

module memory_stage
   import cpu_pkg::*;
#(
   parameter int MEM_AW = 8
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              run,
   input  logic [DATA_W-1:0] alu_m,
   input  logic [DATA_W-1:0] st_data_m,
   input  opcode_e           opc_m,
   input  logic [REG_AW-1:0] rd_m,
   input  logic              we_m,
   input  logic              valid_m,
   input  logic              host_we_dmem,
   input  logic [MEM_AW-1:0] host_addr,
   input  logic [DATA_W-1:0] host_wdata,
   output logic [DATA_W-1:0] host_rdata,
   output logic              wb_we,
   output logic [REG_AW-1:0] wb_rd,
   output logic [DATA_W-1:0] wb_data,
   output logic              halted
);

   logic [DATA_W-1:0] dmem [2**MEM_AW];
   logic [MEM_AW-1:0] addr_m;
   logic              st_en;
   logic [DATA_W-1:0] ld_w;     // Load data in writeback
   logic [DATA_W-1:0] alu_w;
   logic              is_ld_w;

   assign addr_m = alu_m[MEM_AW-1:0];
   assign st_en  = run && valid_m && (opc_m == ST);

   always_ff @(posedge clk) begin
      if (st_en) begin
         dmem[addr_m] <= st_data_m;
      end else if (!run && host_we_dmem) begin
         dmem[host_addr] <= host_wdata;
      end
      ld_w       <= dmem[addr_m];
      host_rdata <= dmem[host_addr];   // Second read port for the host
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_we  <= 1'b0;
         halted <= 1'b0;
      end else begin
         wb_we <= we_m;
         if (valid_m && opc_m == HALT) halted <= 1'b1;
      end
   end

   // Memory/writeback payload
   always_ff @(posedge clk) begin
      wb_rd   <= rd_m;
      alu_w   <= alu_m;
      is_ld_w <= (opc_m == LD);
   end

   assign wb_data = is_ld_w ? ld_w : alu_w;

endmodule

`default_nettype wire

/* hw/cpu_top.sv */
`default_nettype none
// Five-stage 16-bit pipeline: fetch, decode, execute, memory, writeback
// Host port is only usable while run is low. host_sel 0 = imem, 1 = dmem
// After halted, a new program needs a reset

module cpu_top
   import cpu_pkg::*;
#(
   parameter int MEM_AW = 8
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              run,
   input  logic              host_we,
   input  logic              host_sel,
   input  logic [MEM_AW-1:0] host_addr,
   input  logic [DATA_W-1:0] host_wdata,
   output logic [DATA_W-1:0] host_rdata,
   output logic              halted,
   output logic              err
);

   // Host write enables per memory
   logic host_we_imem;
   logic host_we_dmem;

   // Fetch/decode
   logic [DATA_W-1:0] instr_d;
   logic [DATA_W-1:0] pc_d;
   logic              valid_d;

   // Hazard and redirect control
   logic              stall;
   logic              bubble;
   logic              redirect;
   logic [DATA_W-1:0] redirect_pc;
   logic [REG_AW-1:0] rs_d;
   logic [REG_AW-1:0] rt_d;
   logic              uses_rs_d;
   logic              uses_rt_d;

   // Decode/execute
   opcode_e           opc_e;
   cpu_pkg::alu_op_e  alu_op_e;
   logic [DATA_W-1:0] a_e;
   logic [DATA_W-1:0] b_e;
   logic [DATA_W-1:0] imm_e;
   logic [DATA_W-1:0] pc_e;
   logic [REG_AW-1:0] rd_e;
   logic              we_e;
   logic              valid_e;

   // Execute/memory
   logic [DATA_W-1:0] alu_m;
   logic [DATA_W-1:0] st_data_m;
   opcode_e           opc_m;
   logic [REG_AW-1:0] rd_m;
   logic              we_m;
   logic              valid_m;

   // Writeback to the register file
   logic              wb_we;
   logic [REG_AW-1:0] wb_rd;
   logic [DATA_W-1:0] wb_data;

   assign host_we_imem = host_we && !host_sel;
   assign host_we_dmem = host_we && host_sel;

   fetch_stage #(.MEM_AW(MEM_AW)) fetch_stage_inst (
      .clk          (clk),
      .arst_n       (arst_n),
      .run          (run),
      .stall        (stall),
      .redirect     (redirect),
      .redirect_pc  (redirect_pc),
      .host_we_imem (host_we_imem),
      .host_addr    (host_addr),
      .host_wdata   (host_wdata),
      .halt_seen    (halted),
      .instr_d      (instr_d),
      .pc_d         (pc_d),
      .valid_d      (valid_d)
   );

   hazard_unit hazard_unit_inst (
      .rs_d      (rs_d),
      .rt_d      (rt_d),
      .uses_rs_d (uses_rs_d),
      .uses_rt_d (uses_rt_d),
      .valid_d   (valid_d),
      .rd_e      (rd_e),
      .we_e      (we_e),
      .rd_m      (rd_m),
      .we_m      (we_m),
      .stall     (stall),
      .bubble    (bubble)
   );

   decode_stage decode_stage_inst (
      .clk       (clk),
      .arst_n    (arst_n),
      .instr_d   (instr_d),
      .pc_d      (pc_d),
      .valid_d   (valid_d),
      .bubble    (bubble),
      .flush     (redirect),
      .wb_we     (wb_we),
      .wb_rd     (wb_rd),
      .wb_data   (wb_data),
      .rs_d      (rs_d),
      .rt_d      (rt_d),
      .uses_rs_d (uses_rs_d),
      .uses_rt_d (uses_rt_d),
      .opc_e     (opc_e),
      .alu_op_e  (alu_op_e),
      .a_e       (a_e),
      .b_e       (b_e),
      .imm_e     (imm_e),
      .pc_e      (pc_e),
      .rd_e      (rd_e),
      .we_e      (we_e),
      .valid_e   (valid_e),
      .err       (err)
   );

   execute_stage execute_stage_inst (
      .clk         (clk),
      .arst_n      (arst_n),
      .opc_e       (opc_e),
      .alu_op_e    (alu_op_e),
      .a_e         (a_e),
      .b_e         (b_e),
      .imm_e       (imm_e),
      .pc_e        (pc_e),
      .rd_e        (rd_e),
      .we_e        (we_e),
      .valid_e     (valid_e),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .alu_m       (alu_m),
      .st_data_m   (st_data_m),
      .opc_m       (opc_m),
      .rd_m        (rd_m),
      .we_m        (we_m),
      .valid_m     (valid_m)
   );

   memory_stage #(.MEM_AW(MEM_AW)) memory_stage_inst (
      .clk          (clk),
      .arst_n       (arst_n),
      .run          (run),
      .alu_m        (alu_m),
      .st_data_m    (st_data_m),
      .opc_m        (opc_m),
      .rd_m         (rd_m),
      .we_m         (we_m),
      .valid_m      (valid_m),
      .host_we_dmem (host_we_dmem),
      .host_addr    (host_addr),
      .host_wdata   (host_wdata),
      .host_rdata   (host_rdata),
      .wb_we        (wb_we),
      .wb_rd        (wb_rd),
      .wb_data      (wb_data),
      .halted       (halted)
   );

endmodule

`default_nettype wire

/* test/tb_cpu_tests.svh */
// Directed tests for tb_cpu_top. Each builds a program in prog and runs it
// r1..r7 are loaded first, then stored to dmem 0x41..0x47 just before HALT
// Branch offsets are in bytes from the address after the branch
`ifndef TB_CPU_TESTS_SVH
`define TB_CPU_TESTS_SVH

function automatic logic [15:0] op_r(logic [1:0] func, int rd, int rs, int rt);
   return {ALU_R, 3'(rs), 3'(rt), 3'(rd), func};
endfunction

// ADDI, LD and ST. For ST the rd field names the data register
function automatic logic [15:0] op_i(opcode_e opc, int rd, int rs, int imm);
   return {opc, 3'(rs), 3'(rd), 5'(imm)};
endfunction

function automatic logic [15:0] op_lbi(int rd, int imm);
   return {LBI, 3'(rd), 8'(imm)};
endfunction

function automatic logic [15:0] op_br(opcode_e opc, int rs, int off);
   return {opc, 3'(rs), 8'(off)};
endfunction

function automatic logic [15:0] op_j(int off);
   return {J, 11'(off)};
endfunction

task automatic start_program();
   prog.delete();
   for (int r = 1; r < 8; r++) prog.push_back(op_lbi(r, 16 * r + r));
endtask

task automatic end_program();
   prog.push_back(op_lbi(0, 8'h40));                   // Base, used at once
   for (int r = 1; r < 8; r++) prog.push_back(op_i(ST, r, 0, r));
   prog.push_back({HALT, 11'h000});
endtask

task automatic test_reset_halt();
   prog.delete();
   prog.push_back({HALT, 11'h000});    // Nothing may touch dmem
   execute_test("reset_halt");
endtask

task automatic test_dependent_alu();
   start_program();
   prog.push_back(op_lbi(1, -5));
   prog.push_back(op_i(ADDI, 2, 1, 7));
   prog.push_back(op_r(FUNC_ADD, 3, 1, 2));
   prog.push_back(op_r(FUNC_SUB, 4, 3, 1));
   prog.push_back(op_r(FUNC_XOR, 5, 4, 3));
   prog.push_back(op_r(FUNC_AND, 6, 5, 1));
   prog.push_back(op_i(ADDI, 7, 6, -16));
   prog.push_back(op_r(FUNC_ADD, 1, 7, 7));
   end_program();
   execute_test("dependent_alu");
endtask

task automatic test_load_store();
   start_program();
   prog.push_back(op_lbi(1, 8'h20));
   prog.push_back(op_lbi(2, 8'h5c));
   prog.push_back(op_i(ST, 2, 1, 3));
   prog.push_back(op_i(ADDI, 3, 1, 3));     // Same address, computed
   prog.push_back(op_i(LD, 4, 3, 0));
   prog.push_back(op_r(FUNC_ADD, 5, 4, 4)); // Load result used next
   prog.push_back(op_i(ST, 5, 3, 1));
   prog.push_back(op_i(LD, 6, 1, 4));
   prog.push_back(op_i(LD, 7, 1, -1));      // Untouched fill word
   prog.push_back(op_r(FUNC_XOR, 2, 7, 6));
   end_program();
   execute_test("load_store");
endtask

task automatic test_branches();
   start_program();
   prog.push_back(op_lbi(1, 0));
   prog.push_back(op_lbi(2, 3));
   prog.push_back(op_br(BEQZ, 1, 4));       // Taken
   prog.push_back(op_i(ADDI, 3, 3, 1));
   prog.push_back(op_i(ADDI, 4, 4, 1));
   prog.push_back(op_br(BEQZ, 2, 2));       // Not taken
   prog.push_back(op_i(ADDI, 5, 2, 1));
   prog.push_back(op_br(BNEZ, 2, 4));       // Taken
   prog.push_back(op_lbi(6, 8'h11));
   prog.push_back(op_lbi(7, 8'h22));
   prog.push_back(op_br(BNEZ, 1, 2));       // Not taken
   prog.push_back(op_i(ADDI, 1, 1, 9));
   prog.push_back(op_j(4));
   prog.push_back(op_i(ADDI, 3, 3, 2));
   prog.push_back(op_i(ADDI, 4, 4, 2));
   prog.push_back(op_i(ADDI, 2, 2, -1));    // Loop runs three times
   prog.push_back(op_i(ADDI, 6, 6, 3));
   prog.push_back(op_br(BNEZ, 2, -6));
   end_program();
   execute_test("branches");
endtask

task automatic test_illegal_opcode();
   start_program();
   prog.push_back(op_lbi(1, 7));
   prog.push_back({5'b11111, 11'h000});
   prog.push_back(op_i(ADDI, 2, 1, 1));
   prog.push_back({5'b00010, 11'h7ff});     // Register fields all set
   prog.push_back(op_i(ADDI, 3, 2, 1));
   end_program();
   execute_test("illegal_opcode");
endtask

task automatic test_random_alu();
   for (int k = 0; k < 3; k++) begin
      start_program();
      prog.push_back(op_lbi(1, random_bits(8)));
      prog.push_back(op_i(ADDI, 1, 1, random_bits(5)));
      prog.push_back(op_lbi(2, random_bits(8)));
      prog.push_back(op_i(ADDI, 2, 2, random_bits(5)));
      prog.push_back(op_r(FUNC_ADD, 3, 1, 2));
      prog.push_back(op_r(FUNC_SUB, 4, 1, 2));
      prog.push_back(op_r(FUNC_XOR, 5, 1, 2));
      prog.push_back(op_r(FUNC_AND, 6, 1, 2));
      prog.push_back(op_r(FUNC_SUB, 7, 2, 1));
      end_program();
      execute_test($sformatf("random_alu_%0d", k));
   end
endtask

`endif

/* test/tb_cpu_top.sv */
`default_nettype none
// Each test resets the DUT, reloads both memories through the host port, runs to
// halted and compares every data-memory word with an instruction-level model
// Register values are never read directly. Programs store them to data memory

module tb_cpu_top
   import cpu_pkg::*;
();

   localparam int MEM_AW      = 8;
   localparam int MEM_WORDS   = 2**MEM_AW;
   localparam int RUN_TIMEOUT = 2000;   // Cycles per program

   logic              clk;
   logic              arst_n;
   logic              run;
   logic              host_we;
   logic              host_sel;
   logic [MEM_AW-1:0] host_addr;
   logic [DATA_W-1:0] host_wdata;
   logic [DATA_W-1:0] host_rdata;
   logic              halted;
   logic              err;

   int                errors;
   int                checks;
   logic [31:0]       lfsr_state;
   logic [DATA_W-1:0] prog [$];               // Program of the current test
   logic [DATA_W-1:0] imem_image [MEM_WORDS];
   logic [DATA_W-1:0] model_mem [MEM_WORDS];
   logic [DATA_W-1:0] model_reg [8];
   logic              model_err;

   cpu_top #(.MEM_AW(MEM_AW)) cpu_top_inst (
      .clk        (clk),
      .arst_n     (arst_n),
      .run        (run),
      .host_we    (host_we),
      .host_sel   (host_sel),
      .host_addr  (host_addr),
      .host_wdata (host_wdata),
      .host_rdata (host_rdata),
      .halted     (halted),
      .err        (err)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   // Galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic int random_bits(int n);
      int v;
      v = 0;
      repeat (n) begin
         v          = (v << 1) | int'(lfsr_state[0]);
         lfsr_state = lfsr_next(lfsr_state);
      end
      return v;
   endfunction

   // Odd multiplier gives every address its own word
   function automatic logic [DATA_W-1:0] dmem_fill_word(int a);
      return (16'(a) * 16'h9e37) ^ 16'h5a5a;
   endfunction

   task automatic reset_dut();
      @(posedge clk);
      arst_n  <= 1'b0;
      run     <= 1'b0;
      host_we <= 1'b0;
      repeat (5) @(posedge clk);
      arst_n <= 1'b1;
   endtask

   task automatic host_write(logic sel, int addr, logic [DATA_W-1:0] data);
      @(posedge clk);
      host_we    <= 1'b1;
      host_sel   <= sel;
      host_addr  <= MEM_AW'(addr);
      host_wdata <= data;
      @(posedge clk);              // Memory write happens on this edge
      host_we <= 1'b0;
   endtask

   task automatic host_read(int addr, output logic [DATA_W-1:0] data);
      @(posedge clk);
      host_addr <= MEM_AW'(addr);
      @(posedge clk);
      @(negedge clk);
      data = host_rdata;
   endtask

   task automatic load_memories();
      for (int a = 0; a < MEM_WORDS; a++) begin
         imem_image[a] = (a < prog.size()) ? prog[a] : {HALT, 11'h000};
         model_mem[a]  = dmem_fill_word(a);
         host_write(1'b0, a, imem_image[a]);
         host_write(1'b1, a, model_mem[a]);
      end
   endtask

   task automatic report_and_finish();
      $display("Checks: %0d  Errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   endtask

   task automatic run_program(string name);
      int cycles;
      cycles = 0;
      @(posedge clk);
      run <= 1'b1;
      @(negedge clk);
      while (!halted && cycles < RUN_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (halted) begin
         @(posedge clk);
         run <= 1'b0;
      end else begin
         errors++;
         $display("Timeout: %s did not raise halted within %0d cycles", name, RUN_TIMEOUT);
         report_and_finish();
      end
   endtask

   // Sequential ISA model that runs one instruction per step
   task automatic model_run();
      logic [DATA_W-1:0] pc;
      logic [DATA_W-1:0] ins;
      logic [DATA_W-1:0] a;
      logic [DATA_W-1:0] b;
      logic [DATA_W-1:0] imm5;
      logic [DATA_W-1:0] imm8;
      logic [MEM_AW-1:0] addr;
      logic              done;
      pc        = '0;
      done      = 1'b0;
      model_err = 1'b0;
      for (int r = 0; r < 8; r++) model_reg[r] = 'x;
      for (int steps = 0; steps < RUN_TIMEOUT && !done; steps++) begin
         ins  = imem_image[pc[MEM_AW:1]];
         pc   = pc + 16'd2;
         a    = model_reg[ins[10:8]];
         b    = model_reg[ins[7:5]];
         imm5 = {{11{ins[4]}}, ins[4:0]};
         imm8 = {{8{ins[7]}}, ins[7:0]};
         addr = MEM_AW'(a + imm5);
         case (ins[15:11])
            HALT: done = 1'b1;
            NOP: ;
            ALU_R: begin
               case (ins[1:0])
                  FUNC_ADD: model_reg[ins[4:2]] = a + b;
                  FUNC_SUB: model_reg[ins[4:2]] = a - b;
                  FUNC_XOR: model_reg[ins[4:2]] = a ^ b;
                  default:  model_reg[ins[4:2]] = a & b;
               endcase
            end
            ADDI: model_reg[ins[7:5]] = a + imm5;
            LBI:  model_reg[ins[10:8]] = imm8;
            LD:   model_reg[ins[7:5]] = model_mem[addr];
            ST:   model_mem[addr] = b;
            BEQZ: if (a == '0) pc = pc + imm8;
            BNEZ: if (a != '0) pc = pc + imm8;
            J:    pc = pc + {{5{ins[10]}}, ins[10:0]};
            default: model_err = 1'b1;   // Illegal opcode runs as NOP
         endcase
      end
   endtask

   task automatic compare_dmem(string name);
      logic [DATA_W-1:0] word;
      for (int a = 0; a < MEM_WORDS; a++) begin
         host_read(a, word);
         checks++;
         if (word !== model_mem[a]) begin
            errors++;
            $display("** Error at %0t: %s: dmem[%0d] = %h, expected %h",
                     $time, name, a, word, model_mem[a]);
         end
      end
   endtask

   task automatic execute_test(string name);
      int errors_before;
      errors_before = errors;
      reset_dut();
      @(negedge clk);
      checks++;
      if (halted !== 1'b0 || err !== 1'b0) begin
         errors++;
         $display("** Error at %0t: %s: halted=%b err=%b after reset, expected 0",
                  $time, name, halted, err);
      end
      load_memories();
      run_program(name);
      if (halted) begin
         model_run();
         checks++;
         if (err !== model_err) begin
            errors++;
            $display("** Error at %0t: %s: err = %b, expected %b",
                     $time, name, err, model_err);
         end
         compare_dmem(name);
         $display("%s done, %0d errors", name, errors - errors_before);
      end
   endtask

   `include "tb_cpu_tests.svh"

   initial begin
      arst_n     <= 1'b0;
      run        <= 1'b0;
      host_we    <= 1'b0;
      host_sel   <= 1'b0;
      host_addr  <= '0;
      host_wdata <= '0;
      errors     = 0;
      checks     = 0;
      lfsr_state = 32'h65f7bfd8;
      test_reset_halt();
      test_dependent_alu();
      test_load_store();
      test_branches();
      test_illegal_opcode();
      test_random_alu();
      report_and_finish();
   end

endmodule

`default_nettype wire

/* list.f */
+incdir+test
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/hazard_unit.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/cpu_top.sv
test/tb_cpu_top.sv
